// ==== run_sim.sh ====
#!/bin/sh
# build and run the dispatch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dispatch_tb -f verilog.f -o dispatch_sim \
    && ./obj_dir/dispatch_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== sim/dispatch_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module dispatch_tb;

    // pushes over all tests set the watchdog limit
    localparam int total_pushes = 98;
    localparam int cycle_limit  = 4 * total_pushes + 200;

    logic                         clk;
    logic                         i_arst_n;
    logic                         i_push_valid;
    logic                         i_issue_stall;
    dual_issue_pkg::queue_entry_t i_push_entry;
    dual_issue_pkg::wb_port_t     i_wb;
    logic                         o_full;
    dual_issue_pkg::issue_slot_t  o_issue_a;
    dual_issue_pkg::issue_slot_t  o_issue_b;
    logic [1:0]                   o_issue_num;

    // reference model state
    dual_issue_pkg::queue_entry_t mq[$];
    logic [31:0]                  mregs[32];
    logic                         m_pend;
    logic [4:0]                   m_pend_rd;
    logic [1:0]                   exp_num;
    logic [1:0]                   issue_log[$];
    logic [1:0]                   exp_log[$];
    logic [31:0]                  prog[$];
    logic [31:0]                  pc_next;
    logic                         checking;
    integer                       seed;
    int                           errors;
    int                           cycles;

    dispatch_top i_dut (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_push_valid  (i_push_valid),
        .i_push_entry  (i_push_entry),
        .i_issue_stall (i_issue_stall),
        .i_wb          (i_wb),
        .o_full        (o_full),
        .o_issue_a     (o_issue_a),
        .o_issue_b     (o_issue_b),
        .o_issue_num   (o_issue_num)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference decode and pairing
    ////////////////////////////////////////////////////////////////////////////

    function automatic dual_issue_pkg::decoded_t dec_model(input logic [31:0] w);
        dual_issue_pkg::decoded_t d;
        logic [31:0]              sx;
        sx = {{20{w[21]}}, w[21:10]};
        d = '0;
        d.rd = w[4:0];
        d.rs1 = w[9:5];
        d.rs2 = w[14:10];
        d.uses_rs2 = 1'b1;
        d.rd_we = 1'b1;
        case (w[31:26])
            6'h01, 6'h02, 6'h03, 6'h04: d.inst_class = dual_issue_pkg::cls_alu;
            6'h08, 6'h10, 6'h30: begin
                if (w[31:26] == 6'h08) d.inst_class = dual_issue_pkg::cls_alu;
                else if (w[31:26] == 6'h10) d.inst_class = dual_issue_pkg::cls_load;
                else d.inst_class = dual_issue_pkg::cls_csr;
                d.rs2 = 5'd0;
                d.uses_rs2 = 1'b0;
                d.imm = sx;
            end
            6'h11, 6'h18: begin
                d.inst_class = (w[31:26] == 6'h11) ? dual_issue_pkg::cls_store
                                                   : dual_issue_pkg::cls_branch;
                d.rs2 = w[4:0];
                d.rd_we = 1'b0;
                d.imm = sx;
            end
            6'h20, 6'h21: d.inst_class = dual_issue_pkg::cls_muldiv;
            default: begin
                d.inst_class = dual_issue_pkg::cls_illegal;
                d.rs2 = 5'd0;
                d.uses_rs2 = 1'b0;
                d.rd_we = 1'b0;
            end
        endcase
        return d;
    endfunction

    function automatic logic reads(input dual_issue_pkg::decoded_t d, input logic [4:0] r);
        return (r != 5'd0) && ((d.rs1 == r) || (d.uses_rs2 && (d.rs2 == r)));
    endfunction

    function automatic logic [1:0] model_count();
        dual_issue_pkg::decoded_t da;
        dual_issue_pkg::decoded_t db;
        if (i_issue_stall || mq.size() == 0) return 2'd0;
        da = dec_model(mq[0].instruction);
        if (m_pend && reads(da, m_pend_rd)) return 2'd0;
        if (mq.size() < 2) return 2'd1;
        db = dec_model(mq[1].instruction);
        if (m_pend && reads(db, m_pend_rd)) return 2'd1;
        if (da.inst_class != dual_issue_pkg::cls_alu) return 2'd1;
        if (da.rd_we && reads(db, da.rd)) return 2'd1;
        return 2'd2;
    endfunction

    function automatic logic [31:0] mk3r(input logic [5:0] op, input logic [4:0] rd,
                                         input logic [4:0] rj, input logic [4:0] rk);
        return {op, 11'd0, rk, rj, rd};
    endfunction

    function automatic logic [31:0] mkri(input logic [5:0] op, input logic [4:0] rd,
                                         input logic [4:0] rj, input logic [11:0] imm);
        return {op, 4'd0, imm, rj, rd};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // checking
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_val(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_slot(input string tag, input dual_issue_pkg::issue_slot_t got,
                              input dual_issue_pkg::queue_entry_t e);
        dual_issue_pkg::decoded_t d;
        d = dec_model(e.instruction);
        check_val({tag, " pc"}, 64'(got.pc), 64'(e.pc));
        check_val({tag, " decoded"}, 64'(got.decoded), 64'(d));
        check_val({tag, " rdata1"}, 64'(got.rdata1), 64'(mregs[d.rs1]));
        check_val({tag, " rdata2"}, 64'(got.rdata2), 64'(mregs[d.rs2]));
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (checking) begin
            exp_num = model_count();
            check_val("issue count", 64'(o_issue_num), 64'(exp_num));
            check_val("full", 64'(o_full), 64'(mq.size() == 8));
            check_val("valid a", 64'(o_issue_a.valid), 64'(exp_num != 2'd0));
            check_val("valid b", 64'(o_issue_b.valid), 64'(exp_num == 2'd2));
            if (exp_num != 2'd0) check_slot("slot a", o_issue_a, mq[0]);
            if (exp_num == 2'd2) check_slot("slot b", o_issue_b, mq[1]);
            if (!i_issue_stall && mq.size() > 0) issue_log.push_back(o_issue_num);
        end
    end

    // model state advances with the DUT
    always @(posedge clk) begin
        dual_issue_pkg::decoded_t da;
        dual_issue_pkg::decoded_t db;
        logic                     ld_a;
        logic                     ld_b;
        logic                     was_full;
        if (i_arst_n && checking) begin
            ld_a = 1'b0;
            ld_b = 1'b0;
            da = '0;
            db = '0;
            if (exp_num != 2'd0) begin
                da = dec_model(mq[0].instruction);
                ld_a = da.inst_class == dual_issue_pkg::cls_load;
            end
            if (exp_num == 2'd2) begin
                db = dec_model(mq[1].instruction);
                ld_b = db.inst_class == dual_issue_pkg::cls_load;
            end
            m_pend = ld_a || ld_b;
            if (ld_b) m_pend_rd = db.rd;
            else if (ld_a) m_pend_rd = da.rd;
            was_full = mq.size() == 8;
            for (int i = 0; i < int'(exp_num); i++) void'(mq.pop_front());
            if (i_push_valid && !was_full) mq.push_back(i_push_entry);
            if (i_wb.we && i_wb.addr != 5'd0) mregs[i_wb.addr] = i_wb.data;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: tests did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic wb_write(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        i_wb <= {1'b1, addr, data};
        @(posedge clk);
        i_wb <= '0;
    endtask

    task automatic fill_stalled();
        @(posedge clk);
        i_issue_stall <= 1'b1;
        foreach (prog[i]) begin
            @(posedge clk);
            i_push_valid <= 1'b1;
            i_push_entry <= {prog[i], pc_next};
            pc_next = pc_next + 32'd4;
        end
        @(posedge clk);
        i_push_valid <= 1'b0;
    endtask

    task automatic release_drain();
        @(posedge clk);
        i_issue_stall <= 1'b0;
        issue_log.delete();
        @(negedge clk);
        while (mq.size() != 0) @(negedge clk);
    endtask

    task automatic check_log(input string what);
        check_val({what, " log length"}, 64'(issue_log.size()), 64'(exp_log.size()));
        foreach (exp_log[i]) begin
            if (i < issue_log.size()) check_val(what, 64'(issue_log[i]), 64'(exp_log[i]));
        end
    endtask

    task automatic pair_case(input logic [31:0] w0, input logic [31:0] w1,
                             input logic [1:0] exp);
        prog = {w0, w1};
        fill_stalled();
        release_drain();
        check_val("pair count", 64'(issue_log.size() > 0 ? issue_log[0] : 2'bxx), 64'(exp));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        check_val("full after reset", 64'(o_full), 64'd0);
        check_val("count after reset", 64'(o_issue_num), 64'd0);
        check_val("valid a after reset", 64'(o_issue_a.valid), 64'd0);
        check_val("valid b after reset", 64'(o_issue_b.valid), 64'd0);
    endtask

    task automatic test_alu_pairs();
        wb_write(5'd1, 32'h1111_0001);
        wb_write(5'd2, 32'h2222_0002);
        wb_write(5'd3, 32'h3333_0003);
        wb_write(5'd4, 32'hdead_beef);
        prog = {mk3r(6'h01, 5'd5, 5'd1, 5'd2), mk3r(6'h02, 5'd6, 5'd3, 5'd4),
                mk3r(6'h03, 5'd7, 5'd1, 5'd0), mkri(6'h08, 5'd8, 5'd2, 12'hffb),
                mk3r(6'h04, 5'd9, 5'd4, 5'd3), mkri(6'h08, 5'd10, 5'd0, 12'h7ff)};
        fill_stalled();
        release_drain();
        exp_log = {2'd2, 2'd2, 2'd2};
        check_log("alu pairs");
    endtask

    task automatic test_pairing_limits();
        logic [31:0] add_b;
        add_b = mk3r(6'h01, 5'd6, 5'd2, 5'd3);
        pair_case(mkri(6'h10, 5'd5, 5'd1, 12'd8), add_b, 2'd1);
        pair_case(mkri(6'h11, 5'd2, 5'd1, 12'd4), add_b, 2'd1);
        pair_case(mk3r(6'h20, 5'd5, 5'd1, 5'd2), add_b, 2'd1);
        pair_case(mkri(6'h30, 5'd5, 5'd1, 12'd0), add_b, 2'd1);
        pair_case(mkri(6'h18, 5'd2, 5'd1, 12'd16), mkri(6'h18, 5'd4, 5'd3, 12'd8), 2'd1);
        pair_case(mkri(6'h18, 5'd2, 5'd1, 12'd16), mkri(6'h10, 5'd7, 5'd3, 12'd0), 2'd1);
        pair_case(mkri(6'h18, 5'd2, 5'd1, 12'd16), mkri(6'h11, 5'd4, 5'd3, 12'd0), 2'd1);
        pair_case(mk3r(6'h01, 5'd5, 5'd1, 5'd2), mk3r(6'h02, 5'd6, 5'd5, 5'd3), 2'd1);
        // r0 destination carries no dependency
        pair_case(mk3r(6'h01, 5'd0, 5'd1, 5'd2), mk3r(6'h02, 5'd6, 5'd0, 5'd3), 2'd2);
    endtask

    task automatic test_load_use();
        prog = {mkri(6'h10, 5'd5, 5'd1, 12'd0), mk3r(6'h01, 5'd6, 5'd5, 5'd2)};
        fill_stalled();
        release_drain();
        exp_log = {2'd1, 2'd0, 2'd1};
        check_log("load use on a");
        prog = {mkri(6'h10, 5'd5, 5'd1, 12'd0), mk3r(6'h01, 5'd6, 5'd1, 5'd2),
                mk3r(6'h01, 5'd7, 5'd5, 5'd1)};
        fill_stalled();
        release_drain();
        exp_log = {2'd1, 2'd1, 2'd1};
        check_log("load use on b");
    endtask

    task automatic test_backpressure();
        prog.delete();
        for (int i = 0; i < 9; i++) prog.push_back(mkri(6'h08, 5'(11 + i), 5'd1, 12'(i)));
        fill_stalled();
        @(negedge clk);
        check_val("full while stalled", 64'(o_full), 64'd1);
        release_drain();
        exp_log = {2'd2, 2'd2, 2'd2, 2'd2};
        check_log("drain");
    endtask

    task automatic test_random_stream();
        logic [5:0]  ops[12];
        logic [31:0] w;
        ops = '{6'h01, 6'h02, 6'h03, 6'h04, 6'h08, 6'h10, 6'h11, 6'h18, 6'h20, 6'h21,
                6'h30, 6'h3f};
        for (int i = 0; i < 60; i++) begin
            w = $random(seed);
            w[31:26] = ops[int'($unsigned($random(seed)) % 32'd12)];
            // small register numbers make hazards frequent
            w[14:10] = {2'd0, w[12:10]};
            w[9:5] = {2'd0, w[7:5]};
            w[4:0] = {2'd0, w[2:0]};
            @(posedge clk);
            i_push_valid <= 1'b1;
            i_push_entry <= {w, pc_next};
            i_issue_stall <= ($random(seed) & 3) == 0;
            pc_next = pc_next + 32'd4;
        end
        @(posedge clk);
        i_push_valid <= 1'b0;
        release_drain();
    endtask

    initial begin
        seed = 32'h4d54_dd5c;
        errors = 0;
        cycles = 0;
        checking = 1'b0;
        pc_next = 32'h0000_1000;
        m_pend = 1'b0;
        m_pend_rd = 5'd0;
        exp_num = 2'd0;
        foreach (mregs[i]) mregs[i] = '0;
        i_arst_n = 1'b0;
        i_push_valid = 1'b0;
        i_push_entry = '0;
        i_issue_stall = 1'b0;
        i_wb = '0;
        repeat (2) @(posedge clk);
        i_arst_n <= 1'b1;
        @(negedge clk);
        test_reset_state();
        checking = 1'b1;
        test_alu_pairs();
        test_pairing_limits();
        test_load_use();
        test_backpressure();
        test_random_stream();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/issue_control_assertions.sv ====
`default_nettype none
`timescale 1ns/10ps

module issue_control_assertions (
    input wire                            clk,
    input wire                            i_arst_n,
    input wire [1:0]                      i_head_valid,
    input wire dual_issue_pkg::decoded_t  i_dec_a,
    input wire                            i_stall,
    input wire [1:0]                      i_issue_num
);

    ////////////////////////////////////////////////////////////////////////////
    // issue count properties
    ////////////////////////////////////////////////////////////////////////////

    // never more than the valid heads
    count_within_heads: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_issue_num <= ({1'b0, i_head_valid[1]} + {1'b0, i_head_valid[0]}))
        else $error("issue count exceeds valid queue heads");

    count_zero_on_stall: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_stall |-> (i_issue_num == 2'd0))
        else $error("issue count nonzero while stalled");

    // slot B only behind a simple ALU op
    pair_needs_alu_a: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_issue_num == 2'd2) |-> (i_dec_a.inst_class == dual_issue_pkg::cls_alu))
        else $error("slot B issued behind a non-ALU slot A");

endmodule

bind issue_control issue_control_assertions u_assertions (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_head_valid (i_head_valid),
    .i_dec_a      (i_dec_a),
    .i_stall      (i_stall),
    .i_issue_num  (o_issue_num)
);

`default_nettype wire

// ==== src/dispatch_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module dispatch_top (
    input  wire                                clk,
    input  wire                                i_arst_n,
    input  wire                                i_push_valid,
    input  wire dual_issue_pkg::queue_entry_t  i_push_entry,
    input  wire                                i_issue_stall,
    input  wire dual_issue_pkg::wb_port_t      i_wb,
    output logic                               o_full,
    output dual_issue_pkg::issue_slot_t        o_issue_a,
    output dual_issue_pkg::issue_slot_t        o_issue_b,
    output logic [1:0]                         o_issue_num
);

    dual_issue_pkg::queue_entry_t head_a;
    dual_issue_pkg::queue_entry_t head_b;
    dual_issue_pkg::decoded_t     dec_a;
    dual_issue_pkg::decoded_t     dec_b;
    logic [1:0]                   head_valid;
    logic [31:0]                  rdata_a1;
    logic [31:0]                  rdata_a2;
    logic [31:0]                  rdata_b1;
    logic [31:0]                  rdata_b2;

    inst_queue u_queue (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_push_valid (i_push_valid),
        .i_push_entry (i_push_entry),
        .i_pop_num    (o_issue_num),
        .o_head_a     (head_a),
        .o_head_b     (head_b),
        .o_head_valid (head_valid),
        .o_full       (o_full)
    );

    inst_decoder u_dec_a (.i_inst(head_a.instruction), .o_dec(dec_a));
    inst_decoder u_dec_b (.i_inst(head_b.instruction), .o_dec(dec_b));

    issue_regfile u_regfile (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_wb       (i_wb),
        .i_raddr_a1 (dec_a.rs1),
        .i_raddr_a2 (dec_a.rs2),
        .i_raddr_b1 (dec_b.rs1),
        .i_raddr_b2 (dec_b.rs2),
        .o_rdata_a1 (rdata_a1),
        .o_rdata_a2 (rdata_a2),
        .o_rdata_b1 (rdata_b1),
        .o_rdata_b2 (rdata_b2)
    );

    issue_control u_control (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_head_valid (head_valid),
        .i_dec_a      (dec_a),
        .i_dec_b      (dec_b),
        .i_stall      (i_issue_stall),
        .o_issue_num  (o_issue_num)
    );

    // slot valids follow the issue count
    assign o_issue_a = '{valid: (o_issue_num != 2'd0), pc: head_a.pc, decoded: dec_a,
                         rdata1: rdata_a1, rdata2: rdata_a2};
    assign o_issue_b = '{valid: (o_issue_num == 2'd2), pc: head_b.pc, decoded: dec_b,
                         rdata1: rdata_b1, rdata2: rdata_b2};

endmodule

`default_nettype wire

// ==== src/dual_issue_pkg.sv ====
`default_nettype none

package dual_issue_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // queue geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int queue_depth = 8;
    localparam int queue_ptr_w = 3;

    typedef logic [queue_ptr_w-1:0] queue_ptr_t;
    // one extra bit so a full queue is distinguishable from an empty one
    typedef logic [queue_ptr_w:0]   queue_cnt_t;

    ////////////////////////////////////////////////////////////////////////////
    // instruction encoding
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        op_add  = 6'h01,
        op_sub  = 6'h02,
        op_and  = 6'h03,
        op_or   = 6'h04,
        op_addi = 6'h08,
        op_ld   = 6'h10,
        op_st   = 6'h11,
        op_beq  = 6'h18,
        op_mul  = 6'h20,
        op_div  = 6'h21,
        op_csr  = 6'h30
    } opcode_e;

    typedef enum logic [2:0] {
        cls_alu     = 3'd0,
        cls_load    = 3'd1,
        cls_store   = 3'd2,
        cls_branch  = 3'd3,
        cls_muldiv  = 3'd4,
        cls_csr     = 3'd5,
        cls_illegal = 3'd6
    } inst_class_e;

    // three register form
    typedef struct packed {
        opcode_e     opcode;
        logic [10:0] unused;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_3r_t;

    // register plus 12-bit immediate form
    typedef struct packed {
        opcode_e     opcode;
        logic [3:0]  unused;
        logic [11:0] imm12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri12_t;

    typedef union packed {
        fmt_3r_t    r3;
        fmt_2ri12_t ri12;
    } inst_word_u;

    ////////////////////////////////////////////////////////////////////////////
    // pipeline payloads
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        inst_class_e inst_class;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        uses_rs2;
        logic        rd_we;
        logic [31:0] imm;
    } decoded_t;

    typedef struct packed {
        inst_word_u  instruction;
        logic [31:0] pc;
    } queue_entry_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        decoded_t    decoded;
        logic [31:0] rdata1;
        logic [31:0] rdata2;
    } issue_slot_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
    } wb_port_t;

endpackage

`default_nettype wire

// ==== src/inst_decoder.sv ====
`default_nettype none
`timescale 1ns/10ps

module inst_decoder (
    input  wire dual_issue_pkg::inst_word_u i_inst,
    output dual_issue_pkg::decoded_t        o_dec
);

    dual_issue_pkg::inst_class_e cls;
    logic [31:0]                 imm_sext;

    // immediate view of the word
    assign imm_sext = {{20{i_inst.ri12.imm12[11]}}, i_inst.ri12.imm12};

    ////////////////////////////////////////////////////////////////////////////
    // opcode to class
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (i_inst.r3.opcode)
            dual_issue_pkg::op_add,
            dual_issue_pkg::op_sub,
            dual_issue_pkg::op_and,
            dual_issue_pkg::op_or,
            dual_issue_pkg::op_addi: begin
                cls = dual_issue_pkg::cls_alu;
            end
            dual_issue_pkg::op_ld: begin
                cls = dual_issue_pkg::cls_load;
            end
            dual_issue_pkg::op_st: begin
                cls = dual_issue_pkg::cls_store;
            end
            dual_issue_pkg::op_beq: begin
                cls = dual_issue_pkg::cls_branch;
            end
            dual_issue_pkg::op_mul,
            dual_issue_pkg::op_div: begin
                cls = dual_issue_pkg::cls_muldiv;
            end
            dual_issue_pkg::op_csr: begin
                cls = dual_issue_pkg::cls_csr;
            end
            default: begin
                cls = dual_issue_pkg::cls_illegal;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // register fields and immediate
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // 3r defaults
        o_dec            = '0;
        o_dec.inst_class = cls;
        o_dec.rd         = i_inst.r3.rd;
        o_dec.rs1        = i_inst.r3.rj;
        o_dec.rs2        = i_inst.r3.rk;
        o_dec.uses_rs2   = 1'b1;
        o_dec.rd_we      = 1'b1;

        case (cls)
            dual_issue_pkg::cls_alu: begin
                if (i_inst.r3.opcode == dual_issue_pkg::op_addi) begin
                    o_dec.rs2      = 5'd0;
                    o_dec.uses_rs2 = 1'b0;
                    o_dec.imm      = imm_sext;
                end
            end
            dual_issue_pkg::cls_load,
            dual_issue_pkg::cls_csr: begin
                o_dec.rs2      = 5'd0;
                o_dec.uses_rs2 = 1'b0;
                o_dec.imm      = imm_sext;
            end
            // rd is a source here and nothing is written back
            dual_issue_pkg::cls_store,
            dual_issue_pkg::cls_branch: begin
                o_dec.rs2   = i_inst.ri12.rd;
                o_dec.rd_we = 1'b0;
                o_dec.imm   = imm_sext;
            end
            dual_issue_pkg::cls_illegal: begin
                o_dec.rs2      = 5'd0;
                o_dec.uses_rs2 = 1'b0;
                o_dec.rd_we    = 1'b0;
            end
            default: begin
                // mul and div keep the 3r defaults
                o_dec.imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/inst_queue.sv ====
`default_nettype none
`timescale 1ns/10ps

module inst_queue (
    input  wire                                clk,
    input  wire                                i_arst_n,
    input  wire                                i_push_valid,
    input  wire dual_issue_pkg::queue_entry_t  i_push_entry,
    input  wire [1:0]                          i_pop_num,
    output dual_issue_pkg::queue_entry_t       o_head_a,
    output dual_issue_pkg::queue_entry_t       o_head_b,
    output logic [1:0]                         o_head_valid,
    output logic                               o_full
);

    // entry storage
    dual_issue_pkg::queue_entry_t mem [dual_issue_pkg::queue_depth];

    dual_issue_pkg::queue_ptr_t wr_ptr;
    dual_issue_pkg::queue_ptr_t rd_ptr;
    dual_issue_pkg::queue_ptr_t rd_ptr_b;
    dual_issue_pkg::queue_cnt_t count;
    dual_issue_pkg::queue_cnt_t push_inc;
    dual_issue_pkg::queue_cnt_t pop_dec;
    logic                       push_ok;

    ////////////////////////////////////////////////////////////////////////////
    // status
    ////////////////////////////////////////////////////////////////////////////

    // msb of count is only set when all entries are held
    assign o_full = count[dual_issue_pkg::queue_ptr_w];

    // bit 1 for slot A and bit 0 for slot B
    assign o_head_valid[1] = |count;
    assign o_head_valid[0] = |count[dual_issue_pkg::queue_ptr_w:1];

    // pushes into a full queue are lost
    assign push_ok = i_push_valid && !o_full;

    assign push_inc = dual_issue_pkg::queue_cnt_t'(push_ok);
    assign pop_dec  = dual_issue_pkg::queue_cnt_t'(i_pop_num);

    ////////////////////////////////////////////////////////////////////////////
    // head read
    ////////////////////////////////////////////////////////////////////////////

    assign rd_ptr_b = rd_ptr + dual_issue_pkg::queue_ptr_t'(1);

    assign o_head_a = mem[rd_ptr];
    assign o_head_b = mem[rd_ptr_b];

    ////////////////////////////////////////////////////////////////////////////
    // pointer and occupancy update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + dual_issue_pkg::queue_ptr_t'(1);
            end
            // pop count never exceeds occupancy
            rd_ptr <= rd_ptr + pop_dec[dual_issue_pkg::queue_ptr_w-1:0];
            count  <= count + push_inc - pop_dec;
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= i_push_entry;
        end
    end

endmodule

`default_nettype wire

// ==== src/issue_control.sv ====
`default_nettype none
`timescale 1ns/10ps

module issue_control (
    input  wire                            clk,
    input  wire                            i_arst_n,
    input  wire [1:0]                      i_head_valid,
    input  wire dual_issue_pkg::decoded_t  i_dec_a,
    input  wire dual_issue_pkg::decoded_t  i_dec_b,
    input  wire                            i_stall,
    output logic [1:0]                     o_issue_num
);

    // destination of a load issued last cycle
    logic       pend_valid;
    logic [4:0] pend_rd;

    logic a_valid;
    logic b_valid;
    logic lock_a;
    logic lock_b;
    logic a_is_alu;
    logic a_is_br;
    logic b_is_br;
    logic b_is_mem;
    logic double_br;
    logic br_mem;
    logic raw_ab;
    logic pair_ok;
    logic ld_a;
    logic ld_b;

    // true when d reads register r and r is not r0
    function automatic logic reads_reg(input dual_issue_pkg::decoded_t d, input logic [4:0] r);
        return (r != 5'd0) && ((d.rs1 == r) || (d.uses_rs2 && (d.rs2 == r)));
    endfunction

    assign a_valid = i_head_valid[1];
    assign b_valid = i_head_valid[0];

    ////////////////////////////////////////////////////////////////////////////
    // hazard terms
    ////////////////////////////////////////////////////////////////////////////

    assign lock_a = pend_valid && reads_reg(i_dec_a, pend_rd);
    assign lock_b = pend_valid && reads_reg(i_dec_b, pend_rd);

    assign a_is_alu = i_dec_a.inst_class == dual_issue_pkg::cls_alu;
    assign a_is_br  = i_dec_a.inst_class == dual_issue_pkg::cls_branch;
    assign b_is_br  = i_dec_b.inst_class == dual_issue_pkg::cls_branch;
    assign b_is_mem = (i_dec_b.inst_class == dual_issue_pkg::cls_load) ||
                      (i_dec_b.inst_class == dual_issue_pkg::cls_store);

    assign double_br = a_is_br && b_is_br;
    assign br_mem    = a_is_br && b_is_mem;
    assign raw_ab    = i_dec_a.rd_we && reads_reg(i_dec_b, i_dec_a.rd);

    assign pair_ok = b_valid && !lock_b && a_is_alu && !double_br && !br_mem && !raw_ab;

    ////////////////////////////////////////////////////////////////////////////
    // issue count
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (i_stall || !a_valid || lock_a) begin
            o_issue_num = 2'd0;
        end else if (pair_ok) begin
            o_issue_num = 2'd2;
        end else begin
            o_issue_num = 2'd1;
        end
    end

    // load-use interlock
    assign ld_a = (o_issue_num != 2'd0) && (i_dec_a.inst_class == dual_issue_pkg::cls_load);
    assign ld_b = (o_issue_num == 2'd2) && (i_dec_b.inst_class == dual_issue_pkg::cls_load);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pend_valid <= 1'b0;
            pend_rd    <= 5'd0;
        end else begin
            pend_valid <= ld_a || ld_b;
            // younger load wins
            pend_rd    <= ld_b ? i_dec_b.rd : i_dec_a.rd;
        end
    end

endmodule

`default_nettype wire

// ==== src/issue_regfile.sv ====
`default_nettype none
`timescale 1ns/10ps

module issue_regfile (
    input  wire                            clk,
    input  wire                            i_arst_n,
    input  wire dual_issue_pkg::wb_port_t  i_wb,
    input  wire [4:0]                      i_raddr_a1,
    input  wire [4:0]                      i_raddr_a2,
    input  wire [4:0]                      i_raddr_b1,
    input  wire [4:0]                      i_raddr_b2,
    output logic [31:0]                    o_rdata_a1,
    output logic [31:0]                    o_rdata_a2,
    output logic [31:0]                    o_rdata_b1,
    output logic [31:0]                    o_rdata_b2
);

    // r0 has no storage
    logic [31:0] regs [1:31];

    ////////////////////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.we && (i_wb.addr != 5'd0)) begin
            regs[i_wb.addr] <= i_wb.data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read ports
    ////////////////////////////////////////////////////////////////////////////

    // a write shows up one cycle later
    assign o_rdata_a1 = (i_raddr_a1 == 5'd0) ? '0 : regs[i_raddr_a1];
    assign o_rdata_a2 = (i_raddr_a2 == 5'd0) ? '0 : regs[i_raddr_a2];
    assign o_rdata_b1 = (i_raddr_b1 == 5'd0) ? '0 : regs[i_raddr_b1];
    assign o_rdata_b2 = (i_raddr_b2 == 5'd0) ? '0 : regs[i_raddr_b2];

endmodule

`default_nettype wire

// ==== verilog.f ====
src/dual_issue_pkg.sv
src/inst_queue.sv
src/inst_decoder.sv
src/issue_regfile.sv
src/issue_control.sv
src/dispatch_top.sv
sim/issue_control_assertions.sv
sim/dispatch_tb.sv
